// ==== verilog/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data path and address width
`define WORD_SIZE     16
`define NUM_REGS      8
`define PC_REG        7

// instruction field widths
`define OPCODE_BITS   3
`define REG_BITS      3
`define IMM_BITS      9
`define ZERO_BITS     (`IMM_BITS - `REG_BITS)

// first fetch address is PC + 1, so all ones gives address 0
`define PC_RESET      {`WORD_SIZE{1'b1}}

`endif

// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

`include "cpu_cfg.svh"

    typedef logic [`WORD_SIZE-1:0] word_t;
    typedef logic [`REG_BITS-1:0]  reg_idx_t;

    typedef enum logic [`OPCODE_BITS-1:0] {
        OP_MV    = 3'b000,
        OP_MVT_B = 3'b001, // mvt with imm flag, branch without
        OP_ADD   = 3'b010,
        OP_SUB   = 3'b011,
        OP_LD    = 3'b100,
        OP_ST    = 3'b101,
        OP_AND   = 3'b110, // executes as a no-op
        OP_CMP   = 3'b111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_NONE,
        ALU_MOV,
        ALU_MVT,
        ALU_ADD,
        ALU_SUB
    } alu_op_e;

    // encoding matches the rX field of a branch
    typedef enum logic [2:0] {
        COND_NONE = 3'd0,
        COND_EQ   = 3'd1,
        COND_NE   = 3'd2,
        COND_CC   = 3'd3,
        COND_CS   = 3'd4,
        COND_PL   = 3'd5,
        COND_MI   = 3'd6
    } cond_e;

    typedef struct packed {
        logic negative;
        logic zero;
        logic carry;
        logic overflow;
    } flags_t;

    typedef struct packed {
        opcode_e                opcode;
        logic                   imm;
        reg_idx_t               rx;
        logic [`IMM_BITS-1:0]   imm9;
    } instr_imm_t;

    typedef struct packed {
        opcode_e                opcode;
        logic                   imm;
        reg_idx_t               rx;
        logic [`ZERO_BITS-1:0]  zero_bits; // must be zero for register-form cmp
        reg_idx_t               ry;
    } instr_reg_t;

    typedef union packed {
        instr_imm_t i;
        instr_reg_t r;
    } instr_word_u;

    typedef struct packed {
        logic       valid;
        word_t      addr;         // instruction address
        word_t      op1;
        word_t      op2;
        word_t      result;       // fetched word in fetch, alu or load data later
        reg_idx_t   rx;
        reg_idx_t   ry;
        logic       imm;
        logic       writeback;
        logic       read;
        logic       write;
        logic       is_branch;
        logic       update_flags;
        alu_op_e    alu_op;
        cond_e      cond;
    } stage_item_t;

    typedef struct packed {
        logic       en;
        reg_idx_t   idx;
        word_t      value;
    } reg_write_t;

    typedef struct packed {
        word_t      addr;
        word_t      wdata;
        logic       read;
        logic       write;
    } mem_req_t;

endpackage

// ==== verilog/register_file.sv ====
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module register_file import cpu_pkg::*; (
    input  logic        Clock,
    input  logic        Reset,
    input  reg_idx_t    rd_x,
    input  reg_idx_t    rd_y,
    output word_t       x_value,
    output word_t       y_value,
    output word_t       pc,
    input  word_t       pc_next,
    input  logic        pc_we,
    input  reg_write_t  wb
);

    word_t regs [`NUM_REGS];

    assign x_value = regs[rd_x];
    assign y_value = regs[rd_y];
    assign pc      = regs[`PC_REG];

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            regs[`PC_REG] <= `PC_RESET;
        end else begin
            if (pc_we) begin
                regs[`PC_REG] <= pc_next; // sequential fetch
            end
            if (wb.en) begin
                regs[wb.idx] <= wb.value; // Memory2 writeback, taken branch included
            end
        end
    end

    // fetch is frozen by branch_hold while a branch is in flight
    a_no_pc_conflict: assert property (@(posedge Clock) disable iff (Reset)
        !(pc_we && wb.en && wb.idx == reg_idx_t'(`PC_REG)));

endmodule

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage import cpu_pkg::*; (
    input  logic        Clock,
    input  logic        Reset,
    input  word_t       pc,
    input  word_t       instr_in,
    input  logic        hold,
    input  logic        flush,
    output word_t       instr_addr,
    output word_t       pc_next,
    output logic        pc_we,
    output stage_item_t fetch_item
);

    logic  refetch; // PC already points at the word to fetch after a flush
    logic  stop;
    word_t fetch_addr;

    assign stop       = hold || flush;
    assign fetch_addr = (stop || refetch) ? pc : pc + 1'b1;
    assign instr_addr = fetch_addr;
    assign pc_next    = pc + 1'b1;
    assign pc_we      = !stop && !refetch;

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            fetch_item <= '0;
            refetch    <= 1'b0;
        end else if (flush) begin
            // word behind a branch is dropped and fetched again later
            fetch_item <= '0;
            refetch    <= 1'b1;
        end else if (!hold) begin
            fetch_item        <= '0;
            fetch_item.valid  <= 1'b1;
            fetch_item.addr   <= fetch_addr;
            fetch_item.result <= instr_in; // raw instruction word
            refetch           <= 1'b0;
        end
    end

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module decode_stage import cpu_pkg::*; (
    input  logic        Clock,
    input  logic        Reset,
    input  stage_item_t fetch_item,
    input  word_t       x_value,
    input  word_t       y_value,
    input  word_t       pc,
    input  stage_item_t exe_item,
    input  stage_item_t mem1_item,
    input  stage_item_t mem2_item,
    input  logic        mem_stall,
    output reg_idx_t    rd_x,
    output reg_idx_t    rd_y,
    output logic        hazard_stall,
    output logic        branch_hold,
    output stage_item_t decode_item
);

    instr_word_u word;
    stage_item_t item_next;
    word_t       imm_ext;
    logic        uses_x;
    logic        uses_y;
    logic        raw_hit;

    function automatic logic writes_reg(stage_item_t it, reg_idx_t idx);
        return it.valid && it.writeback && (it.rx == idx);
    endfunction

    function automatic logic pending_branch(stage_item_t it);
        return it.valid && it.is_branch;
    endfunction

    assign word    = fetch_item.result;
    assign rd_x    = word.i.rx;
    assign rd_y    = word.r.ry;
    assign imm_ext = {{(`WORD_SIZE-`IMM_BITS){word.i.imm9[`IMM_BITS-1]}}, word.i.imm9};

    always_comb begin
        item_next       = '0;
        uses_x          = 1'b0;
        uses_y          = 1'b0;
        item_next.valid = fetch_item.valid;
        item_next.addr  = fetch_item.addr;
        item_next.rx    = word.i.rx;
        item_next.ry    = word.r.ry;
        item_next.imm   = word.i.imm;
        item_next.op1   = x_value;

        case (word.i.opcode)
            OP_MV: begin
                item_next.alu_op    = ALU_MOV;
                item_next.writeback = 1'b1;
                uses_y              = !word.i.imm;
            end
            OP_MVT_B: begin
                item_next.imm       = 1'b1; // both forms carry imm9
                item_next.writeback = 1'b1;
                if (word.i.imm) begin
                    item_next.alu_op = ALU_MVT;
                end else begin
                    // pc still holds the fetched address, so target is pc + 1 + imm
                    item_next.alu_op    = ALU_ADD;
                    item_next.is_branch = 1'b1;
                    item_next.rx        = reg_idx_t'(`PC_REG);
                    item_next.op1       = pc + 1'b1;
                    item_next.cond      = (word.i.rx == 3'd7) ? COND_NONE : cond_e'(word.i.rx);
                end
            end
            OP_ADD, OP_SUB: begin
                item_next.alu_op    = (word.i.opcode == OP_ADD) ? ALU_ADD : ALU_SUB;
                item_next.writeback = 1'b1;
                uses_x              = 1'b1;
                uses_y              = !word.i.imm;
            end
            OP_LD: begin
                item_next.imm       = 1'b0;
                item_next.read      = 1'b1;
                item_next.writeback = 1'b1;
                uses_y              = 1'b1;
            end
            OP_ST: begin
                item_next.imm   = 1'b0;
                item_next.write = 1'b1; // rX is data, rY is address
                uses_x          = 1'b1;
                uses_y          = 1'b1;
            end
            OP_CMP: begin
                if (word.i.imm || word.r.zero_bits == '0) begin
                    item_next.alu_op       = ALU_SUB;
                    item_next.update_flags = 1'b1;
                    uses_x                 = 1'b1;
                    uses_y                 = !word.i.imm;
                end
            end
            default: ; // and does nothing
        endcase

        item_next.op2 = item_next.imm ? imm_ext : y_value;
    end

    // RAW check against everything not yet written back
    always_comb begin
        raw_hit = 1'b0;
        if (uses_x) begin
            raw_hit = writes_reg(decode_item, word.i.rx) || writes_reg(exe_item, word.i.rx) ||
                      writes_reg(mem1_item, word.i.rx) || writes_reg(mem2_item, word.i.rx);
        end
        if (uses_y) begin
            raw_hit = raw_hit ||
                      writes_reg(decode_item, word.r.ry) || writes_reg(exe_item, word.r.ry) ||
                      writes_reg(mem1_item, word.r.ry) || writes_reg(mem2_item, word.r.ry);
        end
    end

    assign hazard_stall = fetch_item.valid && raw_hit;
    assign branch_hold  = pending_branch(decode_item) || pending_branch(exe_item) ||
                          pending_branch(mem1_item) || pending_branch(mem2_item);

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            decode_item <= '0;
        end else if (!mem_stall) begin
            if (hazard_stall || branch_hold || !fetch_item.valid) begin
                decode_item <= '0; // bubble
            end else begin
                decode_item <= item_next;
            end
        end
    end

    // memory ops stay one-directional all the way to Memory1
    a_rw_exclusive: assert property (@(posedge Clock) disable iff (Reset)
        !(decode_item.read && decode_item.write) && !(exe_item.read && exe_item.write) &&
        !(mem1_item.read && mem1_item.write));

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module execute_stage import cpu_pkg::*; (
    input  logic        Clock,
    input  logic        Reset,
    input  stage_item_t decode_item,
    input  logic        mem_stall,
    output stage_item_t exe_item
);

    flags_t      flags;
    flags_t      flags_next;
    word_t       alu_result;
    logic        carry_out;
    logic        cond_met;
    stage_item_t exe_next;

    always_comb begin
        alu_result = decode_item.op2;
        carry_out  = 1'b0;
        case (decode_item.alu_op)
            ALU_MOV: alu_result = decode_item.op2;
            ALU_MVT: alu_result = {decode_item.op2[7:0], 8'h00};
            ALU_ADD: {carry_out, alu_result} = {1'b0, decode_item.op1} + {1'b0, decode_item.op2};
            ALU_SUB: {carry_out, alu_result} = {1'b0, decode_item.op1} - {1'b0, decode_item.op2};
            default: ; // ld and st pass the address through
        endcase
    end

    always_comb begin
        case (decode_item.cond)
            COND_EQ: cond_met = flags.zero;
            COND_NE: cond_met = !flags.zero;
            COND_CC: cond_met = !flags.carry;
            COND_CS: cond_met = flags.carry;
            COND_PL: cond_met = !flags.negative;
            COND_MI: cond_met = flags.negative;
            default: cond_met = 1'b1;
        endcase
    end

    always_comb begin
        flags_next.negative = alu_result[`WORD_SIZE-1];
        flags_next.zero     = (alu_result == '0);
        flags_next.carry    = carry_out;
        // signed overflow of op1 - op2
        flags_next.overflow = (decode_item.alu_op == ALU_SUB) &&
            (decode_item.op1[`WORD_SIZE-1] != decode_item.op2[`WORD_SIZE-1]) &&
            (alu_result[`WORD_SIZE-1] != decode_item.op1[`WORD_SIZE-1]);
    end

    always_comb begin
        exe_next        = decode_item;
        exe_next.result = alu_result;
        if (!cond_met) begin
            exe_next = '0; // branch not taken
        end
    end

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            exe_item <= '0;
            flags    <= '0;
        end else if (!mem_stall) begin
            exe_item <= exe_next;
            if (decode_item.valid && decode_item.update_flags) begin
                flags <= flags_next;
            end
        end
    end

endmodule

// ==== verilog/memory_stage.sv ====
`timescale 1ns/10ps

module memory_stage import cpu_pkg::*; (
    input  logic        Clock,
    input  logic        Reset,
    input  stage_item_t exe_item,
    input  word_t       data_in,
    input  logic        data_done,
    output mem_req_t    data_req,
    output logic        mem_stall,
    output stage_item_t mem1_item,
    output stage_item_t mem2_item,
    output reg_write_t  wb
);

    stage_item_t mem2_next;
    logic        mem_op;

    assign mem_op    = mem1_item.valid && (mem1_item.read || mem1_item.write);
    assign mem_stall = mem_op && !data_done;

    // request straight from Memory1, held there until data_done
    assign data_req.addr  = mem1_item.op2;
    assign data_req.wdata = mem1_item.op1;
    assign data_req.read  = mem1_item.valid && mem1_item.read;
    assign data_req.write = mem1_item.valid && mem1_item.write;

    always_comb begin
        mem2_next = mem1_item;
        if (mem1_item.read) begin
            mem2_next.result = data_in; // load data sampled with data_done
        end
    end

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            mem1_item <= '0;
            mem2_item <= '0;
        end else if (mem_stall) begin
            mem2_item <= '0; // bubble while waiting
        end else begin
            mem1_item <= exe_item;
            mem2_item <= mem2_next;
        end
    end

    assign wb.en    = mem2_item.valid && mem2_item.writeback;
    assign wb.idx   = mem2_item.rx;
    assign wb.value = mem2_item.result;

    a_req_stable: assert property (@(posedge Clock) disable iff (Reset)
        mem_stall |=> $stable(data_req));

endmodule

// ==== verilog/processor.sv ====
`timescale 1ns/10ps

module processor import cpu_pkg::*; (
    input  logic     Clock,
    input  logic     Reset,
    input  word_t    instr_in,
    input  word_t    data_in,
    input  logic     data_done,
    output word_t    instr_addr,
    output mem_req_t data_req
);

    word_t       pc;
    word_t       pc_next;
    logic        pc_we;
    reg_idx_t    rd_x;
    reg_idx_t    rd_y;
    word_t       x_value;
    word_t       y_value;
    reg_write_t  wb;

    stage_item_t fetch_item;
    stage_item_t decode_item;
    stage_item_t exe_item;
    stage_item_t mem1_item;
    stage_item_t mem2_item;

    logic        mem_stall;
    logic        hazard_stall;
    logic        branch_hold;

    register_file u_regs (
        .Clock   (Clock),
        .Reset   (Reset),
        .rd_x    (rd_x),
        .rd_y    (rd_y),
        .x_value (x_value),
        .y_value (y_value),
        .pc      (pc),
        .pc_next (pc_next),
        .pc_we   (pc_we),
        .wb      (wb)
    );

    fetch_stage u_fetch (
        .Clock      (Clock),
        .Reset      (Reset),
        .pc         (pc),
        .instr_in   (instr_in),
        .hold       (mem_stall || hazard_stall),
        .flush      (branch_hold),
        .instr_addr (instr_addr),
        .pc_next    (pc_next),
        .pc_we      (pc_we),
        .fetch_item (fetch_item)
    );

    decode_stage u_decode (
        .Clock        (Clock),
        .Reset        (Reset),
        .fetch_item   (fetch_item),
        .x_value      (x_value),
        .y_value      (y_value),
        .pc           (pc),
        .exe_item     (exe_item),
        .mem1_item    (mem1_item),
        .mem2_item    (mem2_item),
        .mem_stall    (mem_stall),
        .rd_x         (rd_x),
        .rd_y         (rd_y),
        .hazard_stall (hazard_stall),
        .branch_hold  (branch_hold),
        .decode_item  (decode_item)
    );

    execute_stage u_execute (
        .Clock       (Clock),
        .Reset       (Reset),
        .decode_item (decode_item),
        .mem_stall   (mem_stall),
        .exe_item    (exe_item)
    );

    memory_stage u_memory (
        .Clock     (Clock),
        .Reset     (Reset),
        .exe_item  (exe_item),
        .data_in   (data_in),
        .data_done (data_done),
        .data_req  (data_req),
        .mem_stall (mem_stall),
        .mem1_item (mem1_item),
        .mem2_item (mem2_item),
        .wb        (wb)
    );

endmodule

// ==== testbench/tb_processor.sv ====
`timescale 1ns/10ps

module tb_processor import cpu_pkg::*; ();

    localparam int    NUM_TESTS    = 6;
    localparam int    CYCLE_BUDGET = 2000; // cycles allowed per test
    localparam int    CLK_PERIOD   = 8;
    localparam word_t MARKER_ADDR  = 16'h00ff;

    logic     Clock     = 1'b0;
    logic     Reset     = 1'b1;
    word_t    data_in   = '0;
    logic     data_done = 1'b0;
    word_t    instr_in;
    word_t    instr_addr;
    mem_req_t data_req;

    word_t    rom [256];
    word_t    ram [256];
    word_t    ref_ram [256];       // memory image of the reference run
    int       prog_len     = 0;
    int       errors       = 0;
    int       checks       = 0;
    integer   seed         = 32'hbfa4_58b0;
    logic     random_delay = 1'b0;
    int       marker_count = 0;    // final stores seen by the RAM model
    int       marker_base  = 0;
    logic     serving      = 1'b0;
    int       wait_left    = 0;
    mem_req_t held_req     = '0;

    processor DUT (
        .Clock      (Clock),
        .Reset      (Reset),
        .instr_in   (instr_in),
        .data_in    (data_in),
        .data_done  (data_done),
        .instr_addr (instr_addr),
        .data_req   (data_req)
    );

    assign instr_in = rom[instr_addr[7:0]]; // ROM answers in the same cycle

    always #(CLK_PERIOD / 2) Clock = ~Clock;

    function automatic word_t fill_word(int i);
        return {~i[7:0], i[7:0]};
    endfunction

    task automatic check_word(word_t actual, word_t expected, string name);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_req(mem_req_t actual, mem_req_t expected, string name);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // data RAM answering a request after 0 to 3 cycles when random delays are on
    always @(negedge Clock) begin
        data_done = 1'b0;
        if (Reset) begin
            serving = 1'b0;
            for (int i = 0; i < 256; i++) begin
                ram[i] = fill_word(i);
            end
        end else if (data_req.read || data_req.write) begin
            if (!serving) begin
                serving   = 1'b1;
                held_req  = data_req;
                wait_left = random_delay ? ($random(seed) & 3) : 0;
            end else begin
                check_req(data_req, held_req, "data_req"); // request frozen while waiting
            end
            if (wait_left == 0) begin
                serving   = 1'b0;
                data_done = 1'b1;
                data_in   = ram[data_req.addr[7:0]];
                if (data_req.write) begin
                    ram[data_req.addr[7:0]] = data_req.wdata;
                    if (data_req.addr == MARKER_ADDR) begin
                        marker_count++;
                    end
                end
            end else begin
                wait_left--;
            end
        end
    end

    function automatic word_t imm_form(opcode_e op, int rx, int imm);
        return {op, 1'b1, rx[2:0], imm[8:0]};
    endfunction

    function automatic word_t reg_form(opcode_e op, int rx, int ry);
        return {op, 1'b0, rx[2:0], 6'd0, ry[2:0]};
    endfunction

    function automatic word_t branch_to(cond_e cond, int offset);
        return {OP_MVT_B, 1'b0, cond, offset[8:0]};
    endfunction

    task automatic emit(word_t w);
        rom[prog_len] = w;
        prog_len++;
    endtask

    // holds the DUT in reset while the ROM is rewritten
    task automatic start_test(logic random_on);
        Reset        = 1'b1;
        random_delay = random_on;
        prog_len     = 0;
        marker_base  = marker_count;
        for (int i = 0; i < 256; i++) begin
            rom[i]     = {3'b110, 5'd0, i[7:0]}; // no-op and opcode
            ref_ram[i] = fill_word(i);
        end
    endtask

    task automatic end_with_marker();
        emit(imm_form(OP_MV, 6, MARKER_ADDR));
        emit(reg_form(OP_ST, 6, 6));
    endtask

    task automatic apply_reset();
        Reset = 1'b1;
        repeat (5) @(posedge Clock);
        @(negedge Clock);
        Reset = 1'b0;
    endtask

    task automatic wait_for_marker();
        while (marker_count == marker_base) begin
            @(negedge Clock);
        end
    endtask

    // ISA level model stepping one instruction at a time
    task automatic reference_run(string name);
        word_t       r [8];
        word_t       w;
        word_t       pc;
        word_t       opnd;
        logic [16:0] diff;
        logic        n;
        logic        z;
        logic        c;
        logic        taken;
        logic        done;
        int          steps;
        for (int i = 0; i < 8; i++) begin
            r[i] = '0;
        end
        pc    = '0;
        n     = 1'b0;
        z     = 1'b0;
        c     = 1'b0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < CYCLE_BUDGET) begin
            w    = rom[pc[7:0]];
            opnd = w[12] ? {{7{w[8]}}, w[8:0]} : r[w[2:0]];
            pc   = pc + 16'd1;
            steps++;
            case (w[15:13])
                3'b000: r[w[11:9]] = opnd;
                3'b001: begin
                    if (w[12]) begin
                        r[w[11:9]] = {w[7:0], 8'h00};
                    end else begin
                        case (w[11:9])
                            3'd1:    taken = z;
                            3'd2:    taken = !z;
                            3'd3:    taken = !c;
                            3'd4:    taken = c;
                            3'd5:    taken = !n;
                            3'd6:    taken = n;
                            default: taken = 1'b1;
                        endcase
                        if (taken) begin
                            pc = pc + {{7{w[8]}}, w[8:0]}; // relative to branch + 1
                        end
                    end
                end
                3'b010: r[w[11:9]] = r[w[11:9]] + opnd;
                3'b011: r[w[11:9]] = r[w[11:9]] - opnd;
                3'b100: r[w[11:9]] = ref_ram[r[w[2:0]][7:0]];
                3'b101: begin
                    ref_ram[r[w[2:0]][7:0]] = r[w[11:9]];
                    done = (r[w[2:0]] == MARKER_ADDR);
                end
                3'b111: begin
                    if (w[12] || w[8:3] == 6'd0) begin
                        diff = {1'b0, r[w[11:9]]} - {1'b0, opnd};
                        n    = diff[15];
                        z    = (diff[15:0] == 16'd0);
                        c    = diff[16]; // borrow out
                    end
                end
                default: ;
            endcase
        end
        if (!done) begin
            errors++;
            $display("reference run of %s never reached its final store", name);
        end
    endtask

    task automatic compare_ram(string name);
        reference_run(name);
        for (int i = 0; i < 256; i++) begin
            check_word(ram[i], ref_ram[i], $sformatf("%s ram[%0d]", name, i));
        end
    endtask

    task automatic execute_program(string name);
        apply_reset();
        wait_for_marker();
        compare_ram(name);
    endtask

    task automatic reset_and_fetch_order();
        start_test(1'b0);
        emit(imm_form(OP_MV, 1, 1));
        emit(imm_form(OP_MV, 2, 2));
        emit(imm_form(OP_MV, 3, 3));
        emit(imm_form(OP_MV, 0, 8));
        emit(reg_form(OP_ST, 1, 0));
        end_with_marker();
        apply_reset();
        check_req(data_req, '0, "data_req after reset");
        for (int i = 0; i < 3; i++) begin
            check_word(instr_addr, word_t'(i), "instr_addr");
            @(negedge Clock);
        end
        wait_for_marker();
        compare_ram("reset_fetch");
    endtask

    task automatic immediate_alu();
        start_test(1'b0);
        emit(imm_form(OP_MV, 1, 100));
        emit(imm_form(OP_MVT_B, 2, 'ha5));
        emit(imm_form(OP_ADD, 1, -3));
        emit(imm_form(OP_SUB, 2, 1));
        emit(imm_form(OP_MVT_B, 3, 'h7f));
        emit(imm_form(OP_ADD, 3, -256));
        emit(imm_form(OP_MV, 4, -200));
        emit(imm_form(OP_SUB, 4, 255));
        emit(imm_form(OP_MV, 0, 16));
        for (int k = 1; k <= 4; k++) begin
            emit(reg_form(OP_ST, k, 0));
            emit(imm_form(OP_ADD, 0, 1));
        end
        end_with_marker();
        execute_program("immediate_alu");
    endtask

    task automatic register_chains();
        start_test(1'b0);
        emit(imm_form(OP_MV, 1, 7));
        emit(imm_form(OP_MV, 2, -5));
        emit(reg_form(OP_ADD, 1, 2));
        emit(reg_form(OP_ADD, 2, 1));
        emit(reg_form(OP_SUB, 1, 2));
        emit(reg_form(OP_MV, 3, 1));
        emit(reg_form(OP_SUB, 3, 2));
        emit(reg_form(OP_ADD, 3, 3));
        emit(reg_form(OP_MV, 4, 3));
        emit(reg_form(OP_SUB, 4, 1));
        emit(imm_form(OP_MV, 0, 32));
        for (int k = 1; k <= 4; k++) begin
            emit(reg_form(OP_ST, k, 0));
            emit(imm_form(OP_ADD, 0, 1));
        end
        end_with_marker();
        execute_program("register_chains");
    endtask

    task automatic loads_and_stores();
        start_test(1'b1);
        emit(imm_form(OP_MV, 0, 40));
        emit(reg_form(OP_LD, 1, 0));
        emit(imm_form(OP_MV, 2, 41));
        emit(reg_form(OP_LD, 3, 2));
        emit(reg_form(OP_ADD, 1, 3));
        emit(reg_form(OP_ST, 1, 2));
        emit(reg_form(OP_LD, 4, 2)); // reads back the word just stored
        emit(reg_form(OP_SUB, 4, 0));
        emit(imm_form(OP_MV, 5, 60));
        emit(reg_form(OP_ST, 4, 5));
        emit(reg_form(OP_LD, 3, 5));
        emit(imm_form(OP_ADD, 5, 1));
        emit(reg_form(OP_ST, 3, 5));
        emit(reg_form(OP_ST, 1, 0));
        for (int k = 0; k < 6; k++) begin
            emit(imm_form(OP_MV, 0, 70 + k));
            emit(reg_form(OP_LD, 3, 0));
            emit(imm_form(OP_ADD, 3, k));
            emit(reg_form(OP_ST, 3, 0));
        end
        end_with_marker();
        execute_program("loads_and_stores");
    endtask

    task automatic compare_and_branch();
        start_test(1'b1);
        emit(imm_form(OP_MV, 1, 5));
        emit(imm_form(OP_MV, 3, 9));
        emit(imm_form(OP_MVT_B, 6, 'h12));
        emit(imm_form(OP_ADD, 6, 'h34));
        // store only runs when the branch falls through
        for (int i = 0; i < 14; i++) begin
            emit(imm_form(OP_MV, 5, 80 + i));
            emit(i < 7 ? imm_form(OP_CMP, 1, 5) : reg_form(OP_CMP, 1, 3));
            emit(branch_to(cond_e'(i % 7), 1));
            emit(reg_form(OP_ST, 6, 5));
        end
        emit(imm_form(OP_MV, 1, 3));
        emit(imm_form(OP_MV, 4, 0));
        emit(imm_form(OP_ADD, 4, 2));
        emit(imm_form(OP_SUB, 1, 1));
        emit(imm_form(OP_CMP, 1, 0));
        emit(branch_to(COND_NE, -4)); // back to the add
        emit(imm_form(OP_MV, 5, 100));
        emit(reg_form(OP_ST, 4, 5));
        end_with_marker();
        execute_program("compare_and_branch");
    endtask

    task automatic noop_encodings();
        start_test(1'b0);
        emit(imm_form(OP_MV, 1, 77));
        emit(imm_form(OP_MV, 2, 0));
        emit(imm_form(OP_MV, 0, 120));
        emit(imm_form(OP_CMP, 1, 77));
        emit({3'b111, 1'b0, 3'd1, 6'b101010, 3'd2}); // would clear Z as a cmp
        emit({3'b110, 1'b1, 3'd1, 9'd5});
        emit(branch_to(COND_EQ, 1));
        emit(reg_form(OP_ST, 2, 0));
        emit(imm_form(OP_ADD, 0, 1));
        emit(reg_form(OP_ST, 1, 0));
        end_with_marker();
        execute_program("noop_encodings");
    endtask

    initial begin
        @(negedge Clock);
        reset_and_fetch_order();
        immediate_alu();
        register_chains();
        loads_and_stores();
        compare_and_branch();
        noop_encodings();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * CYCLE_BUDGET * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, a test never finished",
                 NUM_TESTS * CYCLE_BUDGET);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/cpu_pkg.sv
verilog/register_file.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/processor.sv
testbench/tb_processor.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_processor

.PHONY: all run clean

all: run

$(SIM): verilog.f $(wildcard verilog/*.sv verilog/*.svh testbench/*.sv)
	verilator --binary --assert -Wno-fatal --top-module tb_processor -f verilog.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
